/* csr_map_pkg.sv */
package csr_map_pkg;

    localparam int csr_addr_w = 14;
    localparam int xlen = 32;

    // Register numbers
    localparam logic [csr_addr_w-1:0] csr_crmd = 14'h000;
    localparam logic [csr_addr_w-1:0] csr_prmd = 14'h001;
    localparam logic [csr_addr_w-1:0] csr_ecfg = 14'h004;
    localparam logic [csr_addr_w-1:0] csr_estat = 14'h005;
    localparam logic [csr_addr_w-1:0] csr_era = 14'h006;
    localparam logic [csr_addr_w-1:0] csr_badv = 14'h007;
    localparam logic [csr_addr_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_addr_w-1:0] csr_save0 = 14'h030;
    localparam logic [csr_addr_w-1:0] csr_save1 = 14'h031;
    localparam logic [csr_addr_w-1:0] csr_save2 = 14'h032;
    localparam logic [csr_addr_w-1:0] csr_save3 = 14'h033;
    localparam logic [csr_addr_w-1:0] csr_tid = 14'h040;
    localparam logic [csr_addr_w-1:0] csr_tcfg = 14'h041;
    localparam logic [csr_addr_w-1:0] csr_tval = 14'h042;
    localparam logic [csr_addr_w-1:0] csr_ticlr = 14'h044;

    // Interrupt status and enables
    localparam int int_bits = 13;
    localparam logic [int_bits-1:0] ecfg_lie_mask = 13'b1_1011_1111_1111;
    localparam int estat_soft_w = 2;
    localparam int estat_hw_lsb = 2;
    localparam int estat_ti_bit = 11;
    localparam int estat_ecode_lsb = 16;
    localparam int estat_esub_lsb = 22;

    // da, datf and datm set
    localparam logic [xlen-1:0] crmd_reset = 32'h0000_00a8;
    localparam int prmd_pie_bit = 2;
    localparam int eentry_va_lsb = 6;

    localparam int tcfg_en_bit = 0;
    localparam int tcfg_periodic_bit = 1;
    localparam int tcfg_initval_lsb = 2;
    localparam int tcfg_initval_w = 30;
    localparam int ticlr_clr_bit = 0;

    localparam int scratch_slots = 5;

endpackage

/* csr_types_pkg.sv */
package csr_types_pkg;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [csr_map_pkg::csr_addr_w-1:0] paddr;
        logic [csr_map_pkg::xlen-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [csr_map_pkg::xlen-1:0] prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

    // Shared write bus to all register peers
    typedef struct packed {
        logic valid;
        logic [csr_map_pkg::csr_addr_w-1:0] addr;
        logic [csr_map_pkg::xlen-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic exception;
        logic ertn;
        logic [5:0] ecode;
        logic [8:0] esubcode;
        logic [csr_map_pkg::xlen-1:0] era;
        logic [csr_map_pkg::xlen-1:0] badv;
        logic badv_valid;
    } trap_req_t;

    typedef struct packed {
        logic hit;
        logic [csr_map_pkg::xlen-1:0] data;
    } csr_rd_t;

    typedef struct packed {
        logic [22:0] zero;
        logic [1:0] datm;
        logic [1:0] datf;
        logic pg;
        logic da;
        logic ie;
        logic [1:0] plv;
    } crmd_t;

endpackage

/* csr_apb_slave.sv */
module csr_apb_slave (
    input  logic                                clk,
    input  logic                                aresetn,
    input  csr_types_pkg::apb_req_t             apb_req,
    output csr_types_pkg::apb_rsp_t             apb_rsp,
    output csr_types_pkg::csr_wr_t              wr,
    output logic [csr_map_pkg::csr_addr_w-1:0]  rd_addr,
    input  csr_types_pkg::csr_rd_t              rd_trap,
    input  csr_types_pkg::csr_rd_t              rd_timer,
    input  csr_types_pkg::csr_rd_t              rd_scratch
);

    logic setup_q;
    logic access;
    logic any_hit;
    logic [csr_map_pkg::xlen-1:0] rd_data;

    // Remember a setup phase so only a proper access phase counts
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= apb_req.psel && !apb_req.penable;
        end
    end

    assign access = apb_req.psel && apb_req.penable && setup_q;

    assign wr.valid = access && apb_req.pwrite;
    assign wr.addr  = apb_req.paddr;
    assign wr.data  = apb_req.pwdata;
    assign rd_addr  = apb_req.paddr;

    // Peers return zero data when they do not claim the address
    assign any_hit = rd_trap.hit || rd_timer.hit || rd_scratch.hit;
    assign rd_data = rd_trap.data | rd_timer.data | rd_scratch.data;

    // No wait states
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && !any_hit;
    assign apb_rsp.prdata  = rd_data;

endmodule

/* csr_trap_unit.sv */
module csr_trap_unit (
    input  logic                                clk,
    input  logic                                aresetn,
    input  csr_types_pkg::csr_wr_t              wr,
    input  logic [csr_map_pkg::csr_addr_w-1:0]  rd_addr,
    output csr_types_pkg::csr_rd_t              rd,
    input  csr_types_pkg::trap_req_t            trap,
    input  logic [7:0]                          hw_int,
    input  logic                                timer_int,
    output logic                                cpu_interrupt,
    output logic                                int_pending,
    output csr_types_pkg::crmd_t                crmd,
    output logic [csr_map_pkg::xlen-1:0]        era,
    output logic [csr_map_pkg::xlen-1:0]        eentry
);

    csr_types_pkg::crmd_t crmd_wr;
    logic exc_q;
    logic exc_edge;
    logic exc_take;
    logic [1:0] prmd_pplv;
    logic prmd_pie;
    logic [csr_map_pkg::int_bits-1:0] ecfg_lie;
    logic [csr_map_pkg::estat_soft_w-1:0] estat_soft;
    logic [5:0] estat_ecode;
    logic [8:0] estat_esub;
    logic [csr_map_pkg::int_bits-1:0] estat_is;
    logic [csr_map_pkg::xlen-1:0] estat_val;
    logic [csr_map_pkg::xlen-1:0] badv;
    logic [csr_map_pkg::xlen-1-csr_map_pkg::eentry_va_lsb:0] eentry_va;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exc_q <= 1'b0;
        end else begin
            exc_q <= trap.exception;
        end
    end

    // A held exception enters only once, and ertn wins
    assign exc_edge = trap.exception && !exc_q;
    assign exc_take = exc_edge && !trap.ertn;
    assign crmd_wr  = wr.data;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd <= csr_map_pkg::crmd_reset;
        end else if (trap.ertn) begin
            crmd.plv <= prmd_pplv;
            crmd.ie  <= prmd_pie;
        end else if (exc_take) begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
        end else if (wr.valid && wr.addr == csr_map_pkg::csr_crmd) begin
            crmd.plv  <= crmd_wr.plv;
            crmd.ie   <= crmd_wr.ie;
            crmd.datf <= crmd_wr.datf;
            crmd.datm <= crmd_wr.datm;
            // Paging and direct addressing stay exclusive
            if (crmd_wr.pg != crmd_wr.da) begin
                crmd.pg <= crmd_wr.pg;
                crmd.da <= crmd_wr.da;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= 2'd0;
            prmd_pie  <= 1'b0;
        end else if (exc_take) begin
            prmd_pplv <= crmd.plv;
            prmd_pie  <= crmd.ie;
        end else if (wr.valid && wr.addr == csr_map_pkg::csr_prmd) begin
            prmd_pplv <= wr.data[1:0];
            prmd_pie  <= wr.data[csr_map_pkg::prmd_pie_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie <= '0;
        end else if (wr.valid && wr.addr == csr_map_pkg::csr_ecfg) begin
            ecfg_lie <= wr.data[csr_map_pkg::int_bits-1:0] & csr_map_pkg::ecfg_lie_mask;
        end
    end

    // Cause on entry, software interrupt bits from a write
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_soft  <= '0;
            estat_ecode <= 6'd0;
            estat_esub  <= 9'd0;
        end else if (exc_take) begin
            estat_ecode <= trap.ecode;
            estat_esub  <= trap.esubcode;
        end else if (wr.valid && wr.addr == csr_map_pkg::csr_estat) begin
            estat_soft <= wr.data[csr_map_pkg::estat_soft_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (exc_take) begin
            era <= trap.era;
        end else if (wr.valid && wr.addr == csr_map_pkg::csr_era) begin
            era <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (exc_take && trap.badv_valid) begin
            badv <= trap.badv;
        end else if (wr.valid && wr.addr == csr_map_pkg::csr_badv) begin
            badv <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid && wr.addr == csr_map_pkg::csr_eentry) begin
            eentry_va <= wr.data[csr_map_pkg::xlen-1:csr_map_pkg::eentry_va_lsb];
        end
    end

    assign eentry = {eentry_va, {csr_map_pkg::eentry_va_lsb{1'b0}}};

    always_comb begin
        estat_is = '0;
        estat_is[csr_map_pkg::estat_soft_w-1:0] = estat_soft;
        estat_is[csr_map_pkg::estat_hw_lsb +: 8] = hw_int;
        estat_is[csr_map_pkg::estat_ti_bit] = timer_int;
    end

    always_comb begin
        estat_val = '0;
        estat_val[csr_map_pkg::int_bits-1:0] = estat_is;
        estat_val[csr_map_pkg::estat_ecode_lsb +: 6] = estat_ecode;
        estat_val[csr_map_pkg::estat_esub_lsb +: 9] = estat_esub;
    end

    assign int_pending   = |estat_is;
    assign cpu_interrupt = crmd.ie && |(ecfg_lie & estat_is);

    always_comb begin
        rd.hit  = 1'b1;
        rd.data = '0;
        case (rd_addr)
            csr_map_pkg::csr_crmd:   rd.data = crmd;
            csr_map_pkg::csr_prmd:   rd.data = {29'd0, prmd_pie, prmd_pplv};
            csr_map_pkg::csr_ecfg:   rd.data = {19'd0, ecfg_lie};
            csr_map_pkg::csr_estat:  rd.data = estat_val;
            csr_map_pkg::csr_era:    rd.data = era;
            csr_map_pkg::csr_badv:   rd.data = badv;
            csr_map_pkg::csr_eentry: rd.data = eentry;
            default:                 rd.hit = 1'b0;
        endcase
    end

endmodule

/* csr_timer.sv */
module csr_timer (
    input  logic                                clk,
    input  logic                                aresetn,
    input  csr_types_pkg::csr_wr_t              wr,
    input  logic [csr_map_pkg::csr_addr_w-1:0]  rd_addr,
    output csr_types_pkg::csr_rd_t              rd,
    output logic                                timer_int
);

    localparam int pad_w = csr_map_pkg::xlen - csr_map_pkg::tcfg_initval_w;

    logic tcfg_en;
    logic tcfg_periodic;
    logic [csr_map_pkg::tcfg_initval_w-1:0] tcfg_initval;
    logic [csr_map_pkg::xlen-1:0] tval;
    logic [csr_map_pkg::xlen-1:0] load_val;
    logic [csr_map_pkg::xlen-1:0] reload_val;
    logic time_out;
    logic wr_tcfg;
    logic wr_ticlr;

    assign wr_tcfg  = wr.valid && wr.addr == csr_map_pkg::csr_tcfg;
    assign wr_ticlr = wr.valid && wr.addr == csr_map_pkg::csr_ticlr
                      && wr.data[csr_map_pkg::ticlr_clr_bit];

    assign load_val = {{pad_w{1'b0}},
                       wr.data[csr_map_pkg::tcfg_initval_lsb +: csr_map_pkg::tcfg_initval_w]};
    assign reload_val = {{pad_w{1'b0}}, tcfg_initval};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_tcfg) begin
            tcfg_en       <= wr.data[csr_map_pkg::tcfg_en_bit];
            tcfg_periodic <= wr.data[csr_map_pkg::tcfg_periodic_bit];
            tcfg_initval  <= load_val[csr_map_pkg::tcfg_initval_w-1:0];
        end
    end

    // Countdown, restarted by every TCFG write
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else begin
            time_out <= 1'b0;
            if (wr_tcfg) begin
                tval <= load_val;
            end else if (tcfg_en) begin
                if (tval != '0) begin
                    tval     <= tval - 1'b1;
                    time_out <= tval == 1;
                end else if (tcfg_periodic) begin
                    tval <= reload_val;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_int <= 1'b0;
        end else if (wr_ticlr) begin
            timer_int <= 1'b0;
        end else if (time_out) begin
            timer_int <= 1'b1;
        end
    end

    always_comb begin
        rd.hit  = 1'b1;
        rd.data = '0;
        case (rd_addr)
            csr_map_pkg::csr_tcfg: begin
                rd.data[csr_map_pkg::tcfg_en_bit] = tcfg_en;
                rd.data[csr_map_pkg::tcfg_periodic_bit] = tcfg_periodic;
                rd.data[csr_map_pkg::tcfg_initval_lsb +: csr_map_pkg::tcfg_initval_w] =
                    tcfg_initval;
            end
            csr_map_pkg::csr_tval:  rd.data = tval;
            // Write-only clear, reads as zero
            csr_map_pkg::csr_ticlr: rd.data = '0;
            default:                rd.hit = 1'b0;
        endcase
    end

endmodule

/* csr_scratch_bank.sv */
module csr_scratch_bank (
    input  logic                                clk,
    input  logic                                aresetn,
    input  csr_types_pkg::csr_wr_t              wr,
    input  logic [csr_map_pkg::csr_addr_w-1:0]  rd_addr,
    output csr_types_pkg::csr_rd_t              rd
);

    logic [csr_map_pkg::xlen-1:0] regs_q [csr_map_pkg::scratch_slots];
    logic [2:0] wr_slot;
    logic [2:0] rd_slot;

    // SAVE0 to SAVE3 in slots 0 to 3, TID in slot 4
    function automatic logic [2:0] slot_of(input logic [csr_map_pkg::csr_addr_w-1:0] addr);
        case (addr)
            csr_map_pkg::csr_save0: return 3'd0;
            csr_map_pkg::csr_save1: return 3'd1;
            csr_map_pkg::csr_save2: return 3'd2;
            csr_map_pkg::csr_save3: return 3'd3;
            csr_map_pkg::csr_tid:   return 3'd4;
            default:                return 3'd7;
        endcase
    endfunction

    assign wr_slot = slot_of(wr.addr);
    assign rd_slot = slot_of(rd_addr);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < csr_map_pkg::scratch_slots; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr.valid && wr_slot < csr_map_pkg::scratch_slots) begin
            regs_q[wr_slot] <= wr.data;
        end
    end

    assign rd.hit  = rd_slot < csr_map_pkg::scratch_slots;
    assign rd.data = rd.hit ? regs_q[rd_slot] : '0;

endmodule

/* csr_top.sv */
module csr_top (
    input  logic                            clk,
    input  logic                            aresetn,
    input  csr_types_pkg::apb_req_t         apb_req,
    output csr_types_pkg::apb_rsp_t         apb_rsp,
    input  csr_types_pkg::trap_req_t        trap,
    input  logic [7:0]                      hw_int,
    output logic                            cpu_interrupt,
    output logic                            int_pending,
    output csr_types_pkg::crmd_t            crmd,
    output logic [csr_map_pkg::xlen-1:0]    era,
    output logic [csr_map_pkg::xlen-1:0]    eentry
);

    csr_types_pkg::csr_wr_t wr;
    logic [csr_map_pkg::csr_addr_w-1:0] rd_addr;
    csr_types_pkg::csr_rd_t rd_trap;
    csr_types_pkg::csr_rd_t rd_timer;
    csr_types_pkg::csr_rd_t rd_scratch;
    logic timer_int;

    csr_apb_slave i_apb_slave (
        .clk        (clk),
        .aresetn    (aresetn),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .wr         (wr),
        .rd_addr    (rd_addr),
        .rd_trap    (rd_trap),
        .rd_timer   (rd_timer),
        .rd_scratch (rd_scratch)
    );

    csr_trap_unit i_trap_unit (
        .clk           (clk),
        .aresetn       (aresetn),
        .wr            (wr),
        .rd_addr       (rd_addr),
        .rd            (rd_trap),
        .trap          (trap),
        .hw_int        (hw_int),
        .timer_int     (timer_int),
        .cpu_interrupt (cpu_interrupt),
        .int_pending   (int_pending),
        .crmd          (crmd),
        .era           (era),
        .eentry        (eentry)
    );

    csr_timer i_timer (
        .clk       (clk),
        .aresetn   (aresetn),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .rd        (rd_timer),
        .timer_int (timer_int)
    );

    csr_scratch_bank i_scratch_bank (
        .clk     (clk),
        .aresetn (aresetn),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd      (rd_scratch)
    );

endmodule

/* csr_chk.sv */
module csr_chk (
    input  logic                    clk,
    input  logic                    aresetn,
    input  csr_types_pkg::crmd_t    crmd,
    input  logic                    exc_take,
    input  logic                    cpu_interrupt
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench to catch a failed property
    int fail_cnt = 0;

    a_pg_da_exclusive: assert property (
        @(posedge clk) disable iff (!aresetn) crmd.pg != crmd.da
    ) else begin
        $error("CRMD pg and da are equal");
        fail_cnt++;
    end

    a_entry_clears_plv: assert property (
        @(posedge clk) disable iff (!aresetn) exc_take |=> crmd.plv == 2'd0
    ) else begin
        $error("plv not zero one cycle after exception entry");
        fail_cnt++;
    end

    a_irq_needs_ie: assert property (
        @(posedge clk) disable iff (!aresetn) cpu_interrupt |-> crmd.ie
    ) else begin
        $error("cpu_interrupt high while CRMD ie is clear");
        fail_cnt++;
    end

endmodule

bind csr_trap_unit csr_chk i_chk (
    .clk           (clk),
    .aresetn       (aresetn),
    .crmd          (crmd),
    .exc_take      (exc_take),
    .cpu_interrupt (cpu_interrupt)
);

/* tb_csr.sv */
module tb_csr;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 20;
    localparam int n_tests = 6;
    localparam int cycles_per_test = 200;
    localparam int max_initval = 20;

    logic clk;
    logic aresetn;
    csr_types_pkg::apb_req_t apb_req;
    csr_types_pkg::apb_rsp_t apb_rsp;
    csr_types_pkg::trap_req_t trap;
    logic [7:0] hw_int;
    logic cpu_interrupt;
    logic int_pending;
    csr_types_pkg::crmd_t crmd;
    logic [31:0] era;
    logic [31:0] eentry;
    int unsigned cycle_cnt = 0;

    csr_top i_dut (
        .clk           (clk),
        .aresetn       (aresetn),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .trap          (trap),
        .hw_int        (hw_int),
        .cpu_interrupt (cpu_interrupt),
        .int_pending   (int_pending),
        .crmd          (crmd),
        .era           (era),
        .eentry        (eentry)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run;
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Setup phase, access phase, then back to idle
    task automatic apb_xfer(input logic write, input logic [13:0] addr,
                            input logic [31:0] wdata, input logic exp_err,
                            output logic [31:0] rdata);
        @(posedge clk);
        #2;
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = write;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk);
        assert (apb_rsp.pready) else begin
            $display("pready low in the access phase at %0t", $time);
            abort_run();
        end
        check_value("pslverr", apb_rsp.pslverr, exp_err);
        rdata = apb_rsp.prdata;
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [13:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, 1'b0, unused);
    endtask

    task automatic apb_read(input logic [13:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, '0, 1'b0, data);
    endtask

    task automatic check_reg(input string name, input logic [13:0] addr,
                             input logic [31:0] exp);
        logic [31:0] data;
        apb_read(addr, data);
        check_value(name, data, exp);
    endtask

    task automatic test_reset_values;
        check_reg("CRMD", csr_map_pkg::csr_crmd, csr_map_pkg::crmd_reset);
        check_reg("ESTAT", csr_map_pkg::csr_estat, 32'h0);
        check_reg("ECFG", csr_map_pkg::csr_ecfg, 32'h0);
        check_reg("SAVE0", csr_map_pkg::csr_save0, 32'h0);
        check_reg("SAVE1", csr_map_pkg::csr_save1, 32'h0);
        check_reg("SAVE2", csr_map_pkg::csr_save2, 32'h0);
        check_reg("SAVE3", csr_map_pkg::csr_save3, 32'h0);
        @(negedge clk);
        check_value("cpu_interrupt", cpu_interrupt, 1'b0);
        check_value("int_pending", int_pending, 1'b0);
    endtask

    task automatic test_scratch_rw;
        logic [13:0] addrs [5];
        logic [31:0] vals [5];
        logic [31:0] data;
        addrs = '{csr_map_pkg::csr_save0, csr_map_pkg::csr_save1, csr_map_pkg::csr_save2,
                  csr_map_pkg::csr_save3, csr_map_pkg::csr_tid};
        foreach (vals[i]) begin
            vals[i] = $urandom;
            apb_write(addrs[i], vals[i]);
        end
        foreach (vals[i]) begin
            check_reg("scratch register", addrs[i], vals[i]);
        end
        // Bit 10 always set in the written value
        data = $urandom | 32'h0000_0400;
        apb_write(csr_map_pkg::csr_ecfg, data);
        check_reg("ECFG", csr_map_pkg::csr_ecfg, data & 32'h0000_1bff);
        apb_write(csr_map_pkg::csr_ecfg, 32'h0);
        apb_xfer(1'b1, 14'h020, $urandom, 1'b1, data);
        apb_xfer(1'b0, 14'h020, '0, 1'b1, data);
        check_value("prdata of unmapped read", data, 32'h0);
    endtask

    task automatic test_crmd_rules;
        // pg and da both set is illegal, plv and ie still update
        apb_write(csr_map_pkg::csr_crmd, 32'h0000_00bf);
        check_reg("CRMD", csr_map_pkg::csr_crmd, 32'h0000_00af);
        @(negedge clk);
        check_value("crmd port", crmd, 32'h0000_00af);
        apb_write(csr_map_pkg::csr_crmd, 32'h0000_00b0);
        check_reg("CRMD", csr_map_pkg::csr_crmd, 32'h0000_00b0);
        apb_write(csr_map_pkg::csr_crmd, 32'h0000_00a8);
        check_reg("CRMD", csr_map_pkg::csr_crmd, 32'h0000_00a8);
    endtask

    task automatic test_exception;
        logic [31:0] era_v;
        logic [31:0] badv_v;
        logic [31:0] eentry_v;
        logic [31:0] data;
        era_v = $urandom;
        badv_v = $urandom;
        // Entry address on a 64-byte boundary
        eentry_v = $urandom & 32'hffff_ffc0;
        apb_write(csr_map_pkg::csr_eentry, eentry_v);
        check_reg("EENTRY", csr_map_pkg::csr_eentry, eentry_v);
        @(negedge clk);
        check_value("eentry port", eentry, eentry_v);
        apb_write(csr_map_pkg::csr_crmd, 32'h0000_00af);
        @(posedge clk);
        #2;
        trap.exception = 1'b1;
        trap.ecode = 6'h0b;
        trap.era = era_v;
        trap.badv = badv_v;
        trap.badv_valid = 1'b1;
        @(posedge clk);
        #2;
        trap = '0;
        check_reg("CRMD", csr_map_pkg::csr_crmd, 32'h0000_00a8);
        check_reg("PRMD", csr_map_pkg::csr_prmd, 32'h0000_0007);
        apb_read(csr_map_pkg::csr_estat, data);
        check_value("ESTAT ecode", data[21:16], 6'h0b);
        check_reg("ERA", csr_map_pkg::csr_era, era_v);
        check_reg("BADV", csr_map_pkg::csr_badv, badv_v);
        @(negedge clk);
        check_value("era port", era, era_v);
        @(posedge clk);
        #2;
        trap.ertn = 1'b1;
        @(posedge clk);
        #2;
        trap.ertn = 1'b0;
        check_reg("CRMD", csr_map_pkg::csr_crmd, 32'h0000_00af);
    endtask

    task automatic test_interrupts;
        logic [31:0] data;
        apb_write(csr_map_pkg::csr_crmd, 32'h0000_00a8);
        apb_write(csr_map_pkg::csr_ecfg, 32'h0);
        apb_write(csr_map_pkg::csr_estat, 32'h1);
        @(negedge clk);
        check_value("int_pending", int_pending, 1'b1);
        check_value("cpu_interrupt", cpu_interrupt, 1'b0);
        apb_write(csr_map_pkg::csr_ecfg, 32'h1);
        @(negedge clk);
        check_value("cpu_interrupt", cpu_interrupt, 1'b0);
        apb_write(csr_map_pkg::csr_crmd, 32'h0000_00ac);
        @(negedge clk);
        check_value("cpu_interrupt", cpu_interrupt, 1'b1);
        apb_write(csr_map_pkg::csr_estat, 32'h0);
        @(negedge clk);
        check_value("int_pending", int_pending, 1'b0);
        check_value("cpu_interrupt", cpu_interrupt, 1'b0);
        @(posedge clk);
        #2;
        hw_int = 8'h01;
        apb_read(csr_map_pkg::csr_estat, data);
        check_value("ESTAT bit 2", data[2], 1'b1);
        @(negedge clk);
        check_value("int_pending", int_pending, 1'b1);
        check_value("cpu_interrupt", cpu_interrupt, 1'b0);
        @(posedge clk);
        #2;
        hw_int = 8'h00;
        apb_write(csr_map_pkg::csr_ecfg, 32'h0);
    endtask

    task automatic test_timer;
        logic [31:0] data;
        logic seen;
        int unsigned start;
        apb_write(csr_map_pkg::csr_tcfg,
                  (max_initval << csr_map_pkg::tcfg_initval_lsb) |
                  (32'd1 << csr_map_pkg::tcfg_en_bit));
        start = cycle_cnt;
        apb_read(csr_map_pkg::csr_tval, data);
        assert (data != 0 && data <= max_initval) else begin
            $display("TVAL %0d outside 1 to %0d after the TCFG write", data, max_initval);
            abort_run();
        end
        seen = 1'b0;
        while (!seen) begin
            apb_read(csr_map_pkg::csr_estat, data);
            seen = data[csr_map_pkg::estat_ti_bit];
            assert (seen || cycle_cnt - start <= 40) else begin
                $display("Timer interrupt not seen in ESTAT within 40 cycles");
                abort_run();
            end
        end
        apb_write(csr_map_pkg::csr_crmd, 32'h0000_00ac);
        apb_write(csr_map_pkg::csr_ecfg, 32'd1 << csr_map_pkg::estat_ti_bit);
        @(negedge clk);
        check_value("cpu_interrupt", cpu_interrupt, 1'b1);
        apb_write(csr_map_pkg::csr_ticlr, 32'h1);
        apb_read(csr_map_pkg::csr_estat, data);
        check_value("ESTAT timer bit", data[csr_map_pkg::estat_ti_bit], 1'b0);
        @(negedge clk);
        check_value("cpu_interrupt", cpu_interrupt, 1'b0);
        apb_write(csr_map_pkg::csr_tcfg, 32'h0);
    endtask

    initial begin
        #(clk_period * (n_tests * cycles_per_test + max_initval));
        $display("Watchdog timeout after %0d cycles, the tests did not finish", cycle_cnt);
        abort_run();
    end

    initial begin
        wait (i_dut.i_trap_unit.i_chk.fail_cnt != 0);
        $display("A bound assertion in csr_chk failed at %0t", $time);
        abort_run();
    end

    initial begin
        void'($urandom(32'h8b82_a121));
        aresetn = 1'b0;
        apb_req = '0;
        trap = '0;
        hw_int = '0;
        repeat (4) @(posedge clk);
        #2;
        aresetn = 1'b1;
        test_reset_values();
        test_scratch_rw();
        test_crmd_rules();
        test_exception();
        test_interrupts();
        test_timer();
        if (i_dut.i_trap_unit.i_chk.fail_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Bound assertions failed during the run");
            abort_run();
        end
    end

endmodule

/* all.f */
csr_map_pkg.sv
csr_types_pkg.sv
csr_apb_slave.sv
csr_trap_unit.sv
csr_timer.sv
csr_scratch_bank.sv
csr_top.sv
csr_chk.sv
tb_csr.sv

/* Bender.yml */
package:
  name: csr_block

sources:
  - csr_map_pkg.sv
  - csr_types_pkg.sv
  - csr_apb_slave.sv
  - csr_trap_unit.sv
  - csr_timer.sv
  - csr_scratch_bank.sv
  - csr_top.sv
  - target: test
    files:
      - csr_chk.sv
      - tb_csr.sv
